// ==== source/ddr_rd_pkg.sv ====
package ddr_rd_pkg;

    ////////////////////
    // widths and depths
    ////////////////////
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int KEEP_W     = DATA_W / 8;
    localparam int LEN_W      = 9;      // holds 1..256
    localparam int MAX_BURST  = 256;    // axi4 incr limit
    localparam int DESC_DEPTH = 4;      // bursts in flight
    localparam int DATA_DEPTH = 512;    // beats

    // fixed AR codes
    localparam logic [2:0] AXI_SIZE       = 3'($clog2(KEEP_W));
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_CACHE_CODE = 4'b0010;  // modifiable non-bufferable

    ////////////////////
    // channel structs
    ////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;     // beats, not minus one
        logic [KEEP_W-1:0] strb;    // keep on the final beat
    } rd_req_t;

    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [KEEP_W-1:0] strb;
    } frame_desc_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;     // beats minus one
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [3:0]        cache;
    } ar_chan_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } r_chan_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } axis_beat_t;

endpackage

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic i_axis_clk,
    input  logic i_axis_rst,
    input  logic i_push,
    input  T     i_data,
    input  logic i_pop,
    output T     o_head,
    output logic o_not_empty,
    output logic o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, also for non power of two depths
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push     = i_push && !o_full;
    assign do_pop      = i_pop && o_not_empty;
    assign o_full      = (count == CNT_W'(DEPTH));
    assign o_not_empty = (count != '0);
    assign o_head      = mem[rd_ptr];   // fall-through head

    always_ff @(posedge i_axis_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop
            endcase
        end
    end

    a_no_overflow : assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        i_push |-> !o_full)
        else $error("sync_fifo: push while full");

    a_no_underflow : assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        i_pop |-> o_not_empty)
        else $error("sync_fifo: pop while empty");

endmodule

// ==== source/rd_cmd_issue.sv ====
`timescale 1ns/1ps

module rd_cmd_issue (
    input  logic                    i_axis_clk,
    input  logic                    i_axis_rst,
    input  ddr_rd_pkg::rd_req_t     i_req,
    input  logic                    i_req_valid,
    output logic                    o_req_ready,
    output ddr_rd_pkg::ar_chan_t    o_ar,
    output logic                    o_arvalid,
    input  logic                    i_arready,
    output ddr_rd_pkg::frame_desc_t o_desc,
    output logic                    o_desc_valid,
    input  logic                    i_desc_pop
);

    import ddr_rd_pkg::*;

    logic        req_fire;
    logic        ar_fire;
    logic        desc_full;
    frame_desc_t desc_in;

    // one AR held at a time, and a free descriptor slot per burst
    assign o_req_ready = !o_arvalid && !desc_full;
    assign req_fire    = i_req_valid && o_req_ready;
    assign ar_fire     = o_arvalid && i_arready;

    assign desc_in.len  = i_req.len;
    assign desc_in.strb = i_req.strb;

    ////////////////////
    // AR channel
    ////////////////////
    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            o_arvalid <= 1'b0;
        end else if (req_fire) begin
            o_arvalid <= 1'b1;
        end else if (ar_fire) begin
            o_arvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_axis_clk) begin
        if (req_fire) begin
            o_ar.addr  <= i_req.addr;
            o_ar.len   <= 8'(i_req.len - 1'b1);    // axi len is beats - 1
            o_ar.size  <= AXI_SIZE;
            o_ar.burst <= AXI_BURST_INCR;
            o_ar.cache <= AXI_CACHE_CODE;
        end
    end

    // descriptors leave in issue order, so the framer sees bursts in R order
    sync_fifo #(
        .T     (frame_desc_t),
        .DEPTH (DESC_DEPTH)
    ) desc_fifo_i (
        .i_axis_clk  (i_axis_clk),
        .i_axis_rst  (i_axis_rst),
        .i_push      (req_fire),
        .i_data      (desc_in),
        .i_pop       (i_desc_pop),
        .o_head      (o_desc),
        .o_not_empty (o_desc_valid),
        .o_full      (desc_full)
    );

    a_ar_stable : assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar))
        else $error("rd_cmd_issue: AR changed before arready");

    a_req_len_legal : assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        req_fire |-> (i_req.len != '0) && (i_req.len <= LEN_W'(MAX_BURST)))
        else $error("rd_cmd_issue: illegal request length %0d", i_req.len);

endmodule

// ==== source/rd_data_capture.sv ====
`timescale 1ns/1ps

module rd_data_capture (
    input  logic                                i_axis_clk,
    input  logic                                i_axis_rst,
    input  ddr_rd_pkg::r_chan_t                 i_r,
    input  logic                                i_rvalid,
    output logic                                o_rready,
    output logic [ddr_rd_pkg::DATA_W-1:0]       o_data,
    output logic                                o_data_valid,
    input  logic                                i_data_pop,
    output logic                                o_rd_cpl
);

    import ddr_rd_pkg::*;

    logic r_fire;
    logic data_full;

    // backpressure straight from the FIFO level
    assign o_rready = !data_full;
    assign r_fire   = i_rvalid && o_rready;

    ////////////////////
    // beat buffer
    ////////////////////
    sync_fifo #(
        .T     (logic [DATA_W-1:0]),
        .DEPTH (DATA_DEPTH)
    ) data_fifo_i (
        .i_axis_clk  (i_axis_clk),
        .i_axis_rst  (i_axis_rst),
        .i_push      (r_fire),
        .i_data      (i_r.data),
        .i_pop       (i_data_pop),
        .o_head      (o_data),
        .o_not_empty (o_data_valid),
        .o_full      (data_full)
    );

    // one pulse per burst, a cycle after the last R beat
    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            o_rd_cpl <= 1'b0;
        end else begin
            o_rd_cpl <= r_fire && i_r.last;
        end
    end

endmodule

// ==== source/axis_frame_out.sv ====
`timescale 1ns/1ps

module axis_frame_out (
    input  logic                            i_axis_clk,
    input  logic                            i_axis_rst,
    input  ddr_rd_pkg::frame_desc_t         i_desc,
    input  logic                            i_desc_valid,
    output logic                            o_desc_pop,
    input  logic [ddr_rd_pkg::DATA_W-1:0]   i_data,
    input  logic                            i_data_valid,
    output logic                            o_data_pop,
    output ddr_rd_pkg::axis_beat_t          o_axis,
    output logic                            o_axis_tvalid,
    input  logic                            i_axis_tready
);

    import ddr_rd_pkg::*;

    logic [LEN_W-1:0] beat_cnt;     // beat index inside the head frame
    logic             last_beat;
    logic             tx_fire;

    assign last_beat = (beat_cnt == i_desc.len - 1'b1);
    assign tx_fire   = o_axis_tvalid && i_axis_tready;

    ////////////////////
    // stream beat
    ////////////////////
    // needs both a frame descriptor and a buffered beat
    assign o_axis_tvalid = i_desc_valid && i_data_valid;

    assign o_axis.data = i_data;
    assign o_axis.keep = last_beat ? i_desc.strb : {KEEP_W{1'b1}};
    assign o_axis.last = last_beat;

    // pops follow the handshake, low tready stalls both FIFOs
    assign o_data_pop = tx_fire;
    assign o_desc_pop = tx_fire && last_beat;

    always_ff @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            beat_cnt <= '0;
        end else if (tx_fire) begin
            if (last_beat) begin
                beat_cnt <= '0;     // next frame starts at beat 0
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////
    a_axis_stable : assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        o_axis_tvalid && !i_axis_tready |=> o_axis_tvalid && $stable(o_axis))
        else $error("axis_frame_out: stream beat changed while stalled");

    // descriptor is queued at request time, before any of its data returns
    a_desc_before_data : assert property (@(posedge i_axis_clk) disable iff (i_axis_rst)
        i_data_valid |-> i_desc_valid)
        else $error("axis_frame_out: data without a frame descriptor");

endmodule

// ==== source/ddr_read_to_axis.sv ====
`timescale 1ns/1ps

module ddr_read_to_axis (
    input  logic                        i_axis_clk,
    input  logic                        i_axis_rst,
    // request port
    input  ddr_rd_pkg::rd_req_t         i_req,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    // axi4 read address
    output ddr_rd_pkg::ar_chan_t        o_ar,
    output logic                        o_arvalid,
    input  logic                        i_arready,
    // axi4 read data
    input  ddr_rd_pkg::r_chan_t         i_r,
    input  logic                        i_rvalid,
    output logic                        o_rready,
    // axi-stream out
    output ddr_rd_pkg::axis_beat_t      o_axis,
    output logic                        o_axis_tvalid,
    input  logic                        i_axis_tready,
    output logic                        o_rd_cpl
);

    import ddr_rd_pkg::*;

    frame_desc_t       desc;
    logic              desc_valid;
    logic              desc_pop;
    logic [DATA_W-1:0] data;
    logic              data_valid;
    logic              data_pop;

    ////////////////////
    // stages
    ////////////////////
    rd_cmd_issue rd_cmd_issue_i (
        .i_axis_clk   (i_axis_clk),
        .i_axis_rst   (i_axis_rst),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_ar         (o_ar),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .o_desc       (desc),
        .o_desc_valid (desc_valid),
        .i_desc_pop   (desc_pop)
    );

    rd_data_capture rd_data_capture_i (
        .i_axis_clk   (i_axis_clk),
        .i_axis_rst   (i_axis_rst),
        .i_r          (i_r),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .o_data       (data),
        .o_data_valid (data_valid),
        .i_data_pop   (data_pop),
        .o_rd_cpl     (o_rd_cpl)
    );

    axis_frame_out axis_frame_out_i (
        .i_axis_clk    (i_axis_clk),
        .i_axis_rst    (i_axis_rst),
        .i_desc        (desc),
        .i_desc_valid  (desc_valid),
        .o_desc_pop    (desc_pop),
        .i_data        (data),
        .i_data_valid  (data_valid),
        .o_data_pop    (data_pop),
        .o_axis        (o_axis),
        .o_axis_tvalid (o_axis_tvalid),
        .i_axis_tready (i_axis_tready)
    );

endmodule

// ==== sim/axi_rd_slave_model.sv ====
`timescale 1ns/1ps

module axi_rd_slave_model (
    input  logic                 i_axis_clk,
    input  logic                 i_axis_rst,
    input  ddr_rd_pkg::ar_chan_t i_ar,
    input  logic                 i_arvalid,
    output logic                 o_arready,
    output ddr_rd_pkg::r_chan_t  o_r,
    output logic                 o_rvalid,
    input  logic                 i_rready
);

    import ddr_rd_pkg::*;

    ar_chan_t          burst_q[$];      // accepted, not yet fully answered
    int                beat_idx  = 0;
    logic              arready_q = 1'b0;
    logic              rvalid_q  = 1'b0;
    r_chan_t           r_q       = '0;
    logic [ADDR_W-1:0] lo;

    assign o_arready = arready_q;
    assign o_rvalid  = rvalid_q;
    assign o_r       = r_q;

    always @(posedge i_axis_clk or posedge i_axis_rst) begin
        if (i_axis_rst) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            beat_idx = 0;
            burst_q.delete();
        end else begin
            // retire the beat that moved on this edge
            if (rvalid_q && i_rready) begin
                if (r_q.last) begin
                    burst_q.delete(0);
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
            if (i_arvalid && arready_q) burst_q.push_back(i_ar);
            arready_q <= ($urandom % 4) != 0;   // occasional AR stall

            // a presented beat holds until rready
            if (!rvalid_q || i_rready) begin
                if (burst_q.size() != 0 && ($urandom % 3) != 0) begin
                    lo = burst_q[0].addr + ADDR_W'(beat_idx * 8);
                    r_q.data <= {~lo, lo};
                    r_q.last <= (beat_idx == int'(burst_q[0].len));
                    rvalid_q <= 1'b1;
                end else begin
                    rvalid_q <= 1'b0;       // random gap
                end
            end
        end
    end

endmodule

// ==== sim/tb_ddr_read_to_axis.sv ====
`timescale 1ns/1ps

module tb_ddr_read_to_axis;

    import ddr_rd_pkg::*;

    logic       clk       = 1'b0;
    logic       rst       = 1'b1;
    rd_req_t    req       = '0;
    logic       req_valid = 1'b0;
    logic       tready    = 1'b0;
    logic       req_ready;
    ar_chan_t   ar;
    logic       arvalid;
    logic       arready;
    r_chan_t    r;
    logic       rvalid;
    logic       rready;
    axis_beat_t axis;
    logic       tvalid;
    logic       rd_cpl;

    rd_req_t    req_q[$];       // accepted, frame not yet complete
    rd_req_t    ar_exp_q[$];    // accepted, AR not yet seen
    int         beat_idx = 0;
    int         errors = 0;
    int         accepted = 0;
    int         beats_seen = 0;
    int         frames_seen = 0;
    int         ar_seen = 0;
    int         cpl_seen = 0;
    int         data_level = 0;     // beats held in the data FIFO
    int         max_inflight = 0;
    int         watchdog_cycles = 0;
    bit         stall_mode = 1'b0;
    bit         stalled = 1'b0;
    axis_beat_t stall_beat;

    initial begin
        forever #5 clk = ~clk;
    end

    ddr_read_to_axis ddr_read_to_axis_i (
        .i_axis_clk    (clk),
        .i_axis_rst    (rst),
        .i_req         (req),
        .i_req_valid   (req_valid),
        .o_req_ready   (req_ready),
        .o_ar          (ar),
        .o_arvalid     (arvalid),
        .i_arready     (arready),
        .i_r           (r),
        .i_rvalid      (rvalid),
        .o_rready      (rready),
        .o_axis        (axis),
        .o_axis_tvalid (tvalid),
        .i_axis_tready (tready),
        .o_rd_cpl      (rd_cpl)
    );

    axi_rd_slave_model axi_rd_slave_model_i (
        .i_axis_clk (clk),
        .i_axis_rst (rst),
        .i_ar       (ar),
        .i_arvalid  (arvalid),
        .o_arready  (arready),
        .o_r        (r),
        .o_rvalid   (rvalid),
        .i_rready   (rready)
    );

    ////////////////////
    // reference model
    ////////////////////
    function automatic axis_beat_t expected_beat(input rd_req_t rq, input int idx);
        axis_beat_t  b;
        logic [31:0] lo;
        lo     = rq.addr + 32'(idx * 8);   // low word is the beat address
        b.data = {~lo, lo};
        b.last = (idx == int'(rq.len) - 1);
        b.keep = b.last ? rq.strb : 8'hff;
        return b;
    endfunction

    function automatic ar_chan_t expected_ar(input rd_req_t rq);
        ar_chan_t a;
        a.addr  = rq.addr;
        a.len   = 8'(rq.len - 9'd1);
        a.size  = 3'd3;
        a.burst = 2'b01;
        a.cache = 4'b0010;
        return a;
    endfunction

    task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s data=%h keep=%h last=%b, expected data=%h keep=%h last=%b",
                     $time, name, got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
        end
    endtask

    task automatic check_ar(input string name, input ar_chan_t got, input ar_chan_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // monitor and compare
    ////////////////////
    always @(posedge clk) begin
        if (rst) begin
            if (rd_cpl) begin
                errors++;
                $display("completion pulse seen during reset at %0t", $time);
            end
        end else begin
            // ready flags follow from queue and buffer occupancy
            check_flag("o_req_ready", req_ready,
                       (ar_seen == accepted) && (accepted - frames_seen < DESC_DEPTH));
            check_flag("o_rready", rready, data_level < DATA_DEPTH);
            if (req_valid && req_ready) begin
                req_q.push_back(req);
                ar_exp_q.push_back(req);
                accepted++;
                if (req_q.size() > max_inflight) max_inflight = req_q.size();
            end
            if (arvalid && arready) begin
                ar_seen++;
                if (ar_exp_q.size() == 0) begin
                    errors++;
                    $display("AR handshake without an accepted request at %0t", $time);
                end else begin
                    check_ar("o_ar", ar, expected_ar(ar_exp_q.pop_front()));
                end
            end
            if (stalled) begin
                if (!tvalid) begin
                    errors++;
                    $display("stream valid dropped while stalled at %0t", $time);
                end
                check_beat("o_axis (stalled)", axis, stall_beat);
            end
            stalled    = tvalid && !tready;
            stall_beat = axis;
            if (tvalid && tready) begin
                if (req_q.size() == 0) begin
                    errors++;
                    $display("stream beat with no request outstanding at %0t", $time);
                end else begin
                    check_beat("o_axis", axis, expected_beat(req_q[0], beat_idx));
                    beats_seen++;
                    if (beat_idx == int'(req_q[0].len) - 1) begin
                        req_q.delete(0);
                        beat_idx = 0;
                        frames_seen++;
                    end else begin
                        beat_idx++;
                    end
                end
            end
            if (rvalid && rready) data_level++;
            if (tvalid && tready) data_level--;
            if (rd_cpl) cpl_seen++;
        end
    end

    // ready pattern for the stream sink
    always @(posedge clk) begin
        if (rst) begin
            tready <= 1'b0;
        end else if (stall_mode) begin
            tready <= ($urandom % 2) == 0;
        end else begin
            tready <= 1'b1;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    task automatic send_req(input rd_req_t rq);
        req       <= rq;
        req_valid <= 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while (req_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int err_mark);
        $display("test %0d %s: %s (%0d errors)", num, name,
                 (errors == err_mark) ? "ok" : "mismatch", errors - err_mark);
    endtask

    initial begin
        rd_req_t traffic[20];
        int      total_beats;
        int      err_mark;
        void'($urandom(32'h613e_e890));
        $timeformat(-9, 0, " ns", 0);
        total_beats = 257;
        foreach (traffic[i]) begin
            traffic[i].addr = 32'($urandom) & 32'hffff_fff8;
            traffic[i].len  = 9'($urandom_range(1, 256));
            traffic[i].strb = 8'($urandom_range(1, 255));
            total_beats += 2 * int'(traffic[i].len);   // sent twice
        end
        watchdog_cycles = total_beats * 40 + 2000;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        err_mark = errors;
        send_req('{addr: 32'h0000_1000, len: 9'd1, strb: 8'h0f});
        req_valid <= 1'b0;
        wait_drain();
        report_test(1, "single beat", err_mark);

        err_mark = errors;
        send_req('{addr: 32'h0010_0000, len: 9'd256, strb: 8'h3f});
        req_valid <= 1'b0;
        wait_drain();
        report_test(2, "256-beat burst", err_mark);

        err_mark = errors;
        max_inflight = 0;
        foreach (traffic[i]) send_req(traffic[i]);
        req_valid <= 1'b0;
        wait_drain();
        if (max_inflight < 2) begin
            errors++;
            $display("never more than one request in flight during back-to-back traffic");
        end
        report_test(3, "back-to-back requests", err_mark);

        err_mark = errors;
        stall_mode = 1'b1;
        foreach (traffic[i]) send_req(traffic[i]);
        req_valid <= 1'b0;
        wait_drain();
        stall_mode = 1'b0;
        report_test(4, "random tready stalls", err_mark);

        err_mark = errors;
        if (ar_seen != accepted) begin
            errors++;
            $display("%0d AR handshakes for %0d accepted requests", ar_seen, accepted);
        end
        report_test(5, "AR count", err_mark);

        err_mark = errors;
        if (cpl_seen != frames_seen) begin
            errors++;
            $display("%0d completion pulses for %0d completed bursts", cpl_seen, frames_seen);
        end
        report_test(6, "completion count", err_mark);

        $display("summary: %0d requests, %0d frames, %0d beats, %0d ARs, %0d cpl, %0d errors",
                 accepted, frames_seen, beats_seen, ar_seen, cpl_seen, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // limit scales with the requested beats
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: traffic did not drain within %0d cycles", watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== ddr_read_to_axis.f ====
source/ddr_rd_pkg.sv
source/sync_fifo.sv
source/rd_cmd_issue.sv
source/rd_data_capture.sv
source/axis_frame_out.sv
source/ddr_read_to_axis.sv
sim/axi_rd_slave_model.sv
sim/tb_ddr_read_to_axis.sv

// ==== Makefile ====
TOP = tb_ddr_read_to_axis

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f ddr_read_to_axis.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
